// ==== sifhPkg.sv ====
package sifhPkg;

    // **************************************************
    // pass phase
    // **************************************************

    // coarse pass bins on the top bits
    // fine pass bins on full resolution inside the window
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } sifhPhase;

    // **************************************************
    // default sizes, passed down from the top level
    // **************************************************

    // timestamp width
    localparam int DEF_NP = 10;

    // bin address width
    // all-ones bin code marks a discarded sample
    localparam int DEF_NB = 6;

    // pixels sharing one histogram memory
    localparam int DEF_PIXELS = 4;

    // samples per pixel in one acquisition
    localparam int DEF_DATA_NUM = 4;

    // acquisitions per pass
    localparam int DEF_ACQ_NUM = 8;

    // width of one bin counter, saturates at all-ones
    localparam int DEF_COUNT_W = 8;

endpackage

// ==== tdcSequencer.sv ====
module tdcSequencer #(
    parameter int  NP       = sifhPkg::DEF_NP,
    parameter int  PIXELS   = sifhPkg::DEF_PIXELS,
    parameter int  DATA_NUM = sifhPkg::DEF_DATA_NUM,
    parameter int  ACQ_NUM  = sifhPkg::DEF_ACQ_NUM,
    localparam int PIX_W    = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    input  logic [NP-1:0]     data,
    output logic              sampleValid,
    output logic [NP-1:0]     sampleData,
    output logic [PIX_W-1:0]  pixelIdx,
    output sifhPkg::sifhPhase phase,
    output logic              passFirst,
    output logic              passLast
);

    localparam int IN_W  = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    // position of the next accepted sample
    logic [IN_W-1:0]   inCnt;
    logic [PIX_W-1:0]  pixCnt;
    logic [ACQ_W-1:0]  acqCnt;
    sifhPkg::sifhPhase passPhase;

    // wrap points of the nested counters
    logic inWrap;
    logic pixWrap;
    logic acqWrap;

    assign inWrap  = (inCnt == IN_W'(DATA_NUM - 1));
    assign pixWrap = (pixCnt == PIX_W'(PIXELS - 1));
    assign acqWrap = (acqCnt == ACQ_W'(ACQ_NUM - 1));

    // **************************************************
    // sample / pixel / acquisition counters
    // **************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            inCnt     <= '0;
            pixCnt    <= '0;
            acqCnt    <= '0;
            passPhase <= sifhPkg::COARSE;
        end else if (wrEn) begin
            inCnt <= inWrap ? '0 : inCnt + 1'b1;
            if (inWrap) begin
                pixCnt <= pixWrap ? '0 : pixCnt + 1'b1;
                if (pixWrap) begin
                    acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;
                    // last sample of the pass, next one belongs to the other phase
                    if (acqWrap) begin
                        passPhase <= (passPhase == sifhPkg::COARSE) ?
                                     sifhPkg::FINE : sifhPkg::COARSE;
                    end
                end
            end
        end
    end

    // tags travel with the sample, boundaries only on accepted cycles
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleValid <= 1'b0;
            pixelIdx    <= '0;
            phase       <= sifhPkg::COARSE;
            passFirst   <= 1'b0;
            passLast    <= 1'b0;
        end else begin
            sampleValid <= wrEn;
            passFirst   <= wrEn && (inCnt == '0) && (pixCnt == '0) && (acqCnt == '0);
            passLast    <= wrEn && inWrap && pixWrap && acqWrap;
            if (wrEn) begin
                pixelIdx <= pixCnt;
                phase    <= passPhase;
            end
        end
    end

    // timestamp payload
    always_ff @(posedge clk) begin
        if (wrEn) begin
            sampleData <= data;
        end
    end

endmodule

// ==== tdcFilter.sv ====
module tdcFilter #(
    parameter int  NP     = sifhPkg::DEF_NP,
    parameter int  NB     = sifhPkg::DEF_NB,
    parameter int  PIXELS = sifhPkg::DEF_PIXELS,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 sampleValid,
    input  logic [NP-1:0]        sampleData,
    input  logic [PIX_W-1:0]     pixelIdx,
    input  sifhPkg::sifhPhase    phase,
    input  logic                 passFirst,
    input  logic                 passLast,
    input  logic [PIXELS*NP-1:0] winLow,
    output logic                 binValid,
    output logic [NB-1:0]        binAddr,
    output logic [PIX_W-1:0]     binPixel,
    output sifhPkg::sifhPhase    binPhase,
    output logic                 binFirst,
    output logic                 binLast
);

    localparam logic [NB-1:0] DISCARD = '1;
    // widest offset inside the fine window, one short of the discard code
    localparam logic [NP-1:0] FINE_SPAN = NP'((1 << NB) - 2);

    logic [NP-1:0] curLow;
    logic [NP-1:0] offset;
    logic          inWindow;
    logic [NB-1:0] nextAddr;

    // window of the pixel this sample belongs to
    assign curLow   = winLow[pixelIdx*NP +: NP];
    assign offset   = sampleData - curLow;
    assign inWindow = (sampleData >= curLow) && (offset <= FINE_SPAN);

    always_comb begin
        if (phase == sifhPkg::COARSE) begin
            // top bits all-ones lands on the discard code by itself
            nextAddr = sampleData[NP-1 -: NB];
        end else if (inWindow) begin
            nextAddr = offset[NB-1:0];
        end else begin
            nextAddr = DISCARD;
        end
    end

    // **************************************************
    // output register
    // **************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= 1'b0;
            binPhase <= sifhPkg::COARSE;
            binFirst <= 1'b0;
            binLast  <= 1'b0;
        end else begin
            binValid <= sampleValid;
            binFirst <= sampleValid && passFirst;
            binLast  <= sampleValid && passLast;
            if (sampleValid) begin
                binPhase <= phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            binAddr  <= nextAddr;
            binPixel <= pixelIdx;
        end
    end

endmodule

// ==== histBuilder.sv ====
module histBuilder #(
    parameter int  NB      = sifhPkg::DEF_NB,
    parameter int  PIXELS  = sifhPkg::DEF_PIXELS,
    parameter int  COUNT_W = sifhPkg::DEF_COUNT_W,
    localparam int PIX_W   = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               binValid,
    input  logic [NB-1:0]      binAddr,
    input  logic [PIX_W-1:0]   binPixel,
    input  sifhPkg::sifhPhase  binPhase,
    input  logic               binFirst,
    input  logic               binLast,
    output logic               cntValid,
    output logic [COUNT_W-1:0] cntValue,
    output logic [NB-1:0]      cntAddr,
    output logic [PIX_W-1:0]   cntPixel,
    output sifhPkg::sifhPhase  cntPhase,
    output logic               cntFirst,
    output logic               cntLast
);

    localparam int BINS  = 1 << NB;
    localparam int DEPTH = PIXELS * BINS;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [NB-1:0]      DISCARD = '1;
    localparam logic [COUNT_W-1:0] CNT_MAX = '1;

    // one histogram of BINS counters per pixel stacked by pixel index
    logic [COUNT_W-1:0] mem [DEPTH];
    // per-bin valid bits
    // a clear bit means the stored count is stale
    logic [DEPTH-1:0]   binLive;

    logic [IDX_W-1:0]   wrIdx;
    logic               isCount;
    logic [COUNT_W-1:0] oldCnt;
    logic [COUNT_W-1:0] newCnt;

    assign wrIdx   = IDX_W'(binPixel) * IDX_W'(BINS) + IDX_W'(binAddr);
    assign isCount = binValid && (binAddr != DISCARD);

    // **************************************************
    // read-modify-write
    // **************************************************

    always_comb begin
        if (binFirst) begin
            // whole memory is stale at the start of a pass
            oldCnt = '0;
        end else if (binLive[wrIdx]) begin
            // combinational read sees the write of the cycle before
            oldCnt = mem[wrIdx];
        end else begin
            oldCnt = '0;
        end
        // saturate instead of wrapping
        newCnt = (oldCnt == CNT_MAX) ? oldCnt : oldCnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (isCount) begin
            mem[wrIdx] <= newCnt;
        end
    end

    // lazy clear flushed together with the first write of a pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binLive <= '0;
        end else if (binValid) begin
            if (binFirst) begin
                binLive <= '0;
            end
            if (isCount) begin
                binLive[wrIdx] <= 1'b1;
            end
        end
    end

    // discards still pass through so first/last flags survive
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            cntValid <= 1'b0;
            cntPhase <= sifhPkg::COARSE;
            cntFirst <= 1'b0;
            cntLast  <= 1'b0;
        end else begin
            cntValid <= binValid;
            cntFirst <= binValid && binFirst;
            cntLast  <= binValid && binLast;
            if (binValid) begin
                cntPhase <= binPhase;
            end
        end
    end

    // count of zero on a discard
    always_ff @(posedge clk) begin
        if (binValid) begin
            cntValue <= isCount ? newCnt : '0;
            cntAddr  <= binAddr;
            cntPixel <= binPixel;
        end
    end

endmodule

// ==== peakDetector.sv ====
module peakDetector #(
    parameter int  NB      = sifhPkg::DEF_NB,
    parameter int  PIXELS  = sifhPkg::DEF_PIXELS,
    parameter int  COUNT_W = sifhPkg::DEF_COUNT_W,
    localparam int PIX_W   = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 cntValid,
    input  logic [COUNT_W-1:0]   cntValue,
    input  logic [NB-1:0]        cntAddr,
    input  logic [PIX_W-1:0]     cntPixel,
    input  sifhPkg::sifhPhase    cntPhase,
    input  logic                 cntFirst,
    input  logic                 cntLast,
    output logic                 peakValid,
    output sifhPkg::sifhPhase    peakPhase,
    output logic [PIXELS*NB-1:0] peakBins
);

    localparam logic [NB-1:0] DISCARD = '1;

    // running maximum per pixel
    logic [COUNT_W-1:0] maxCnt [PIXELS];
    logic [NB-1:0]      maxBin [PIXELS];
    logic               lastSeen;
    sifhPkg::sifhPhase  lastPhase;
    logic               hasCount;
    logic               beats;

    assign hasCount = cntValid && (cntAddr != DISCARD);
    // strictly greater, so on a tie the bin that got there first keeps it
    assign beats    = cntFirst || (cntValue > maxCnt[cntPixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXELS; p++) begin
                maxCnt[p] <= '0;
                maxBin[p] <= '0;
            end
        end else if (cntValid) begin
            // new pass, all pixels restart
            if (cntFirst) begin
                for (int p = 0; p < PIXELS; p++) begin
                    maxCnt[p] <= '0;
                    maxBin[p] <= '0;
                end
            end
            if (hasCount && beats) begin
                maxCnt[cntPixel] <= cntValue;
                maxBin[cntPixel] <= cntAddr;
            end
        end
    end

    // **************************************************
    // pass end handoff
    // **************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            lastSeen  <= 1'b0;
            lastPhase <= sifhPkg::COARSE;
            peakValid <= 1'b0;
            peakPhase <= sifhPkg::COARSE;
        end else begin
            lastSeen  <= cntValid && cntLast;
            peakValid <= lastSeen;
            if (cntValid && cntLast) begin
                lastPhase <= cntPhase;
            end
            if (lastSeen) begin
                peakPhase <= lastPhase;
            end
        end
    end

    // maxima already hold the last sample here
    always_ff @(posedge clk) begin
        if (lastSeen) begin
            for (int p = 0; p < PIXELS; p++) begin
                peakBins[p*NB +: NB] <= maxBin[p];
            end
        end
    end

endmodule

// ==== windowCalc.sv ====
module windowCalc #(
    parameter int NP     = sifhPkg::DEF_NP,
    parameter int NB     = sifhPkg::DEF_NB,
    parameter int PIXELS = sifhPkg::DEF_PIXELS
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 peakValid,
    input  sifhPkg::sifhPhase    peakPhase,
    input  logic [PIXELS*NB-1:0] peakBins,
    output logic [PIXELS*NP-1:0] winLow,
    output logic [PIXELS*NP-1:0] result,
    output logic                 resultValid
);

    localparam int SHIFT = NP - NB;
    // half window
    localparam logic [NP:0] SB      = (NP + 1)'(1 << (NB - 1));
    // highest lower edge that keeps the window below full scale
    localparam logic [NP:0] LOW_MAX = (NP + 1)'((1 << NP) - (1 << NB) + 1);

    // coarse bin to clamped fine-window lower edge
    function automatic logic [NP-1:0] windowLow(input logic [NB-1:0] bin);
        logic [NP:0] centre;
        logic [NP:0] low;
        centre = (NP + 1)'(bin) << SHIFT;
        low    = (centre >= SB) ? centre - SB : '0;
        if (low > LOW_MAX) begin
            low = LOW_MAX;
        end
        return low[NP-1:0];
    endfunction

    // **************************************************
    // window update / result
    // **************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLow      <= '0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= peakValid && (peakPhase == sifhPkg::FINE);
            if (peakValid) begin
                for (int p = 0; p < PIXELS; p++) begin
                    if (peakPhase == sifhPkg::COARSE) begin
                        winLow[p*NP +: NP] <= windowLow(peakBins[p*NB +: NB]);
                    end else begin
                        // fine bin is relative to the lower edge
                        result[p*NP +: NP] <= winLow[p*NP +: NP] + NP'(peakBins[p*NB +: NB]);
                    end
                end
            end
        end
    end

endmodule

// ==== sifhTop.sv ====
module sifhTop #(
    parameter int NP       = sifhPkg::DEF_NP,
    parameter int NB       = sifhPkg::DEF_NB,
    parameter int PIXELS   = sifhPkg::DEF_PIXELS,
    parameter int DATA_NUM = sifhPkg::DEF_DATA_NUM,
    parameter int ACQ_NUM  = sifhPkg::DEF_ACQ_NUM,
    parameter int COUNT_W  = sifhPkg::DEF_COUNT_W
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 wrEn,
    input  logic [NP-1:0]        data,
    output logic [PIXELS*NP-1:0] result,
    output logic                 resultValid
);

    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    // **************************************************
    // pipeline signals
    // **************************************************

    // sequencer to filter
    logic              sampleValid;
    logic [NP-1:0]     sampleData;
    logic [PIX_W-1:0]  pixelIdx;
    sifhPkg::sifhPhase phase;
    logic              passFirst;
    logic              passLast;

    // filter to histogram
    logic              binValid;
    logic [NB-1:0]     binAddr;
    logic [PIX_W-1:0]  binPixel;
    sifhPkg::sifhPhase binPhase;
    logic              binFirst;
    logic              binLast;

    // histogram to peak detector
    logic               cntValid;
    logic [COUNT_W-1:0] cntValue;
    logic [NB-1:0]      cntAddr;
    logic [PIX_W-1:0]   cntPixel;
    sifhPkg::sifhPhase  cntPhase;
    logic               cntFirst;
    logic               cntLast;

    // peaks forward, window edges back to the filter
    logic                 peakValid;
    sifhPkg::sifhPhase    peakPhase;
    logic [PIXELS*NB-1:0] peakBins;
    logic [PIXELS*NP-1:0] winLow;

    // stage names match port names, so each stage hooks up by name
    tdcSequencer #(.NP(NP), .PIXELS(PIXELS), .DATA_NUM(DATA_NUM), .ACQ_NUM(ACQ_NUM))
        u_seq (.*);

    tdcFilter #(.NP(NP), .NB(NB), .PIXELS(PIXELS))
        u_filter (.*);

    histBuilder #(.NB(NB), .PIXELS(PIXELS), .COUNT_W(COUNT_W))
        u_hist (.*);

    peakDetector #(.NB(NB), .PIXELS(PIXELS), .COUNT_W(COUNT_W))
        u_peak (.*);

    windowCalc #(.NP(NP), .NB(NB), .PIXELS(PIXELS))
        u_win (.*);

endmodule

// ==== tbClock.sv ====
module tbClock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic combin_res
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held low for the first cycles, released away from the rising edge
    initial begin
        combin_res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
    end

endmodule

// ==== sifhTb.sv ====
module sifhTb;

    localparam int NP       = sifhPkg::DEF_NP;
    localparam int NB       = sifhPkg::DEF_NB;
    localparam int PIXELS   = sifhPkg::DEF_PIXELS;
    localparam int DATA_NUM = sifhPkg::DEF_DATA_NUM;
    localparam int ACQ_NUM  = sifhPkg::DEF_ACQ_NUM;
    localparam int COUNT_W  = sifhPkg::DEF_COUNT_W;
    localparam int BINS     = 1 << NB;
    localparam int FULL     = 1 << NP;
    localparam int PASS_LEN = PIXELS * DATA_NUM * ACQ_NUM;
    // edges from the last accepted fine sample to resultValid
    localparam int LATENCY  = 5;
    // coarse pass, gap, fine pass, wait for the result
    localparam int FRAME_CYCLES = 2 * PASS_LEN + 4 + LATENCY + 2;
    // seven frames plus mid-pass idles, reset and the idle check
    localparam int STIM_CYCLES  = 7 * FRAME_CYCLES + PASS_LEN + 20;
    localparam int TIMEOUT      = 2 * STIM_CYCLES + 200;

    logic                 clk;
    logic                 combin_res;
    logic                 wrEn;
    logic [NP-1:0]        data;
    logic [PIXELS*NP-1:0] result;
    logic                 resultValid;

    // frame stimulus in stream order
    // skip marks samples the model leaves out
    logic [NP-1:0] coarseSamp [PASS_LEN];
    logic [NP-1:0] fineSamp   [PASS_LEN];
    bit            skipCoarse [PASS_LEN];
    bit            skipFine   [PASS_LEN];
    int            idleEvery;
    int            modelLow   [PIXELS];
    int            modelPeak  [PIXELS];
    logic [NP-1:0] expResult  [PIXELS];
    logic [31:0]   lfsrState;
    int            valueErrors;
    int            protoErrors;
    int            cycleCount;

    tbClock #(.PERIOD(20), .RESET_CYCLES(10)) u_clock (.clk(clk), .combin_res(combin_res));

    sifhTop #(
        .NP(NP), .NB(NB), .PIXELS(PIXELS),
        .DATA_NUM(DATA_NUM), .ACQ_NUM(ACQ_NUM), .COUNT_W(COUNT_W)
    ) u_sifhTop (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .result(result), .resultValid(resultValid)
    );

    // **************************************************
    // compare tasks and random source
    // **************************************************

    task automatic checkResult(input string name, input logic [NP-1:0] expected,
                               input logic [NP-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkValid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
            valueErrors++;
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    // stepped once per bit drawn
    function automatic logic [31:0] drawBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // value spread around a centre and kept inside the code range
    function automatic int jitter(input int centre, input int bits);
        int v;
        v = centre + int'(drawBits(bits)) - (1 << (bits - 1));
        if (v < 0) v = 0;
        if (v > FULL - 1) v = FULL - 1;
        return v;
    endfunction

    // **************************************************
    // reference model
    // **************************************************

    // first bin to reach the highest count of the pass wins
    task automatic modelPass(input bit finePass);
        int            cnt [PIXELS][BINS];
        int            best [PIXELS];
        int            pix;
        int            bin;
        logic [NP-1:0] s;
        for (int p = 0; p < PIXELS; p++) begin
            best[p] = 0;
            modelPeak[p] = 0;
            for (int b = 0; b < BINS; b++) cnt[p][b] = 0;
        end
        for (int k = 0; k < PASS_LEN; k++) begin
            pix = (k / DATA_NUM) % PIXELS;
            s   = finePass ? fineSamp[k] : coarseSamp[k];
            bin = finePass ? int'(s) - modelLow[pix] : int'(s) >> (NP - NB);
            // outside the fine window or on the reserved all-ones code
            if (bin < 0 || bin > BINS - 2) bin = BINS - 1;
            if (!(finePass ? skipFine[k] : skipCoarse[k]) && bin != BINS - 1) begin
                cnt[pix][bin]++;
                if (cnt[pix][bin] > best[pix]) begin
                    best[pix] = cnt[pix][bin];
                    modelPeak[pix] = bin;
                end
            end
        end
    endtask

    // coarse peak to clamped lower edge
    task automatic modelWindows();
        modelPass(1'b0);
        for (int p = 0; p < PIXELS; p++) begin
            modelLow[p] = (modelPeak[p] << (NP - NB)) - BINS / 2;
            if (modelLow[p] < 0) modelLow[p] = 0;
            if (modelLow[p] > FULL - BINS + 1) modelLow[p] = FULL - BINS + 1;
        end
    endtask

    task automatic modelResults();
        modelPass(1'b1);
        for (int p = 0; p < PIXELS; p++) expResult[p] = NP'(modelLow[p] + modelPeak[p]);
    endtask

    // **************************************************
    // stimulus
    // **************************************************

    task automatic clearFrame();
        idleEvery = 0;
        for (int k = 0; k < PASS_LEN; k++) begin
            skipCoarse[k] = 1'b0;
            skipFine[k] = 1'b0;
        end
    endtask

    // same cluster for both passes of one pixel
    task automatic fillPixel(input int p, input int centre, input int bits);
        for (int k = 0; k < PASS_LEN; k++) begin
            if ((k / DATA_NUM) % PIXELS == p) begin
                coarseSamp[k] = NP'(jitter(centre, bits));
                fineSamp[k] = NP'(jitter(centre, bits));
            end
        end
    endtask

    // no result pulse is allowed while a pass streams
    task automatic streamPass(input bit finePass);
        for (int k = 0; k < PASS_LEN; k++) begin
            @(negedge clk);
            checkValid("resultValid", 1'b0, resultValid);
            wrEn = 1'b1;
            data = finePass ? fineSamp[k] : coarseSamp[k];
            // optional gap but never after the last sample
            if (idleEvery != 0 && k % idleEvery == idleEvery - 1 && k != PASS_LEN - 1) begin
                @(negedge clk);
                checkValid("resultValid", 1'b0, resultValid);
                wrEn = 1'b0;
            end
        end
    endtask

    // resultValid must show up exactly LATENCY edges after the last sample
    task automatic awaitResult();
        for (int i = 1; i <= LATENCY + 2; i++) begin
            @(negedge clk);
            wrEn = 1'b0;
            if (i == LATENCY + 1) begin
                if (resultValid !== 1'b1) begin
                    $display("t=%0t resultValid did not pulse %0d edges after the last sample",
                             $time, LATENCY);
                    protoErrors++;
                end
                for (int p = 0; p < PIXELS; p++) begin
                    checkResult($sformatf("result[%0d]", p), expResult[p], result[p*NP +: NP]);
                end
            end else begin
                checkValid("resultValid", 1'b0, resultValid);
            end
        end
    endtask

    task automatic runFrame();
        modelWindows();
        modelResults();
        streamPass(1'b0);
        // window hazard gap
        repeat (4) begin
            @(negedge clk);
            checkValid("resultValid", 1'b0, resultValid);
            wrEn = 1'b0;
        end
        streamPass(1'b1);
        awaitResult();
    endtask

    // **************************************************
    // tests
    // **************************************************

    task automatic testReset();
        repeat (8) begin
            @(negedge clk);
            checkValid("resultValid", 1'b0, resultValid);
            for (int p = 0; p < PIXELS; p++) begin
                checkResult($sformatf("result[%0d]", p), '0, result[p*NP +: NP]);
            end
        end
    endtask

    task automatic testCluster();
        clearFrame();
        for (int p = 0; p < PIXELS; p++) fillPixel(p, 300 + 120 * p, 4);
        runFrame();
    endtask

    // bin 0 and the highest usable coarse bin
    task automatic testClamp();
        clearFrame();
        fillPixel(0, 6, 3);
        fillPixel(1, 1000, 3);
        fillPixel(2, 520, 4);
        fillPixel(3, 700, 4);
        runFrame();
    endtask

    task automatic testDiscard();
        int pix;
        int low;
        clearFrame();
        for (int p = 0; p < PIXELS; p++) fillPixel(p, 250 + 150 * p, 4);
        idleEvery = 7;
        // reserved top bits in the coarse pass
        for (int k = 0; k < PASS_LEN; k += 5) begin
            coarseSamp[k] = NP'(FULL - 16 + int'(drawBits(4)));
            skipCoarse[k] = 1'b1;
        end
        modelWindows();
        // above and below the window
        // low bits of both offsets alias to bin 2 far from the cluster
        for (int k = 0; k < PASS_LEN; k += 3) begin
            pix = (k / DATA_NUM) % PIXELS;
            low = modelLow[pix];
            fineSamp[k] = (k % 2) ? NP'((low + BINS + 2) % FULL)
                                  : NP'((low + FULL - BINS + 2) % FULL);
            skipFine[k] = 1'b1;
        end
        runFrame();
    endtask

    // two bins alternate and the leading one reaches each count first
    task automatic testTies();
        int seen [PIXELS];
        int pix;
        int c;
        clearFrame();
        for (int p = 0; p < PIXELS; p++) seen[p] = 0;
        for (int k = 0; k < PASS_LEN; k++) begin
            pix = (k / DATA_NUM) % PIXELS;
            c = 208 + 160 * pix;
            if ((seen[pix] % 2 == 0) == (pix % 2 == 0)) begin
                coarseSamp[k] = NP'(c + 16);
                fineSamp[k] = NP'(c + 3);
            end else begin
                coarseSamp[k] = NP'(c);
                fineSamp[k] = NP'(c - 2);
            end
            seen[pix]++;
        end
        runFrame();
    endtask

    // histograms must clear between frames
    task automatic testFrames();
        repeat (3) begin
            clearFrame();
            for (int p = 0; p < PIXELS; p++) fillPixel(p, int'(drawBits(NP)), 5);
            runFrame();
        end
    endtask

    // **************************************************
    // run control
    // **************************************************

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the run did not complete", cycleCount);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        wrEn = 1'b0;
        data = '0;
        lfsrState = 32'hbaba_36f9;
        valueErrors = 0;
        protoErrors = 0;
        @(posedge combin_res);
        testReset();
        testCluster();
        testClamp();
        testDiscard();
        testTies();
        testFrames();
        $display("checks done: %0d value errors, %0d protocol errors", valueErrors, protoErrors);
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
sifhPkg.sv
tdcSequencer.sv
tdcFilter.sv
histBuilder.sv
peakDetector.sv
windowCalc.sv
sifhTop.sv
tbClock.sv
sifhTb.sv
